/* hw/ipv4_cks_acc.sv */
`timescale 1ns/1ps

module ipv4_cks_acc (
  input  logic                              clk,
  input  logic                              fsm_rst,
  input  logic                              cks_clr,
  input  logic                              hdr_en,
  input  logic [ipv4_rx_pkg::HDR_IDX_W-1:0] hdr_idx,
  input  logic [7:0]                        in_dat,
  output logic                              cks_ok
);
  import ipv4_rx_pkg::*;

  logic [CKS_ACC_W-1:0] acc;
  logic [7:0]           hi_byte;
  logic [16:0]          fold_1;
  logic [15:0]          fold_2;

  // high byte of each word waits for its odd partner
  always_ff @(posedge clk) begin
    if (hdr_en && !hdr_idx[0]) begin
      hi_byte <= in_dat;
    end
  end

  // carries pile up above bit 15 and are wrapped around when folded
  always_ff @(posedge clk) begin
    if (fsm_rst || cks_clr) begin
      acc <= '0;
    end else if (hdr_en && hdr_idx[0]) begin
      acc <= acc + {{(CKS_ACC_W - 16){1'b0}}, hi_byte, in_dat};
    end
  end

  // two folds are enough, the second cannot carry again
  assign fold_1 = {1'b0, acc[15:0]} + {{(33 - CKS_ACC_W){1'b0}}, acc[CKS_ACC_W-1:16]};
  assign fold_2 = fold_1[15:0] + {15'd0, fold_1[16]};

  // ones-complement sum over a good header including its checksum is all ones
  assign cks_ok = (fold_2 == 16'hffff);

endmodule

/* hw/ipv4_hdr_capture.sv */
`timescale 1ns/1ps

module ipv4_hdr_capture (
  input  logic                              clk,
  input  logic                              fsm_rst,
  input  logic                              hdr_en,
  input  logic [ipv4_rx_pkg::HDR_IDX_W-1:0] hdr_idx,
  input  logic [7:0]                        in_dat,
  input  logic [31:0]                       dev_ipv4_addr,
  output logic [ipv4_rx_pkg::HDR_IDX_W-1:0] hdr_bytes,
  output logic                              fmt_ok,
  output logic                              addr_ok,
  output logic [31:0]                       meta_src_ip,
  output logic [31:0]                       meta_dst_ip,
  output logic [7:0]                        meta_proto,
  output logic [15:0]                       meta_id,
  output logic [15:0]                       meta_pld_len
);
  import ipv4_rx_pkg::*;

  logic [3:0]  version;
  logic [3:0]  ihl;
  logic [15:0] total_len;

  // fields that steer the controller
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      version   <= '0;
      ihl       <= '0;
      total_len <= '0;
    end else if (hdr_en) begin
      if (hdr_idx == IPV4_OFS_VER_IHL) begin
        version <= in_dat[7:4];
        ihl     <= in_dat[3:0];
      end
      if (hdr_idx == IPV4_OFS_TOTAL_LEN) begin
        total_len[15:8] <= in_dat;
      end
      if (hdr_idx == IPV4_OFS_TOTAL_LEN + 6'd1) begin
        total_len[7:0] <= in_dat;
      end
    end
  end

  // metadata, multi-byte fields shift in msb first
  always_ff @(posedge clk) begin
    if (hdr_en) begin
      if (hdr_idx == IPV4_OFS_ID) begin
        meta_id[15:8] <= in_dat;
      end
      if (hdr_idx == IPV4_OFS_ID + 6'd1) begin
        meta_id[7:0] <= in_dat;
      end
      if (hdr_idx == IPV4_OFS_PROTO) begin
        meta_proto <= in_dat;
      end
      if ((hdr_idx >= IPV4_OFS_SRC_IP) && (hdr_idx < IPV4_OFS_DST_IP)) begin
        meta_src_ip <= {meta_src_ip[23:0], in_dat};
      end
      if ((hdr_idx >= IPV4_OFS_DST_IP) && (hdr_idx < IPV4_MIN_HDR_BYTES)) begin
        meta_dst_ip <= {meta_dst_ip[23:0], in_dat};
      end
    end
  end

  assign hdr_bytes    = {ihl, 2'b00};
  assign meta_pld_len = total_len - {10'd0, hdr_bytes};

  // a packet must carry at least one payload byte
  assign fmt_ok = (version == IPV4_VERSION) &&
                  (hdr_bytes >= IPV4_MIN_HDR_BYTES) &&
                  (total_len > {10'd0, hdr_bytes});

  assign addr_ok = (meta_dst_ip == dev_ipv4_addr) || (meta_dst_ip == IPV4_BROADCAST);

endmodule

/* hw/ipv4_pld_fwd.sv */
`timescale 1ns/1ps

module ipv4_pld_fwd (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        pld_en,
  input  logic        in_val,
  input  logic [7:0]  in_dat,
  input  logic        in_eof,
  input  logic        in_err,
  input  logic [15:0] meta_pld_len,
  output logic        out_val,
  output logic [7:0]  out_dat,
  output logic        out_sof,
  output logic        out_eof,
  output logic        out_err,
  output logic        pld_done
);

  logic [15:0] pld_cnt;
  logic        take;
  logic        last;
  logic        abort;
  logic        fwd;

  // bytes past the payload length are ethernet padding
  assign take = pld_en && in_val && (pld_cnt != meta_pld_len);
  assign last = (pld_cnt + 16'd1 == meta_pld_len);

  // mac error, or eof before the last payload byte
  assign abort = take && (in_err || (in_eof && !last));
  assign fwd   = take && !abort;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pld_cnt  <= '0;
      out_val  <= 1'b0;
      out_sof  <= 1'b0;
      out_eof  <= 1'b0;
      out_err  <= 1'b0;
      pld_done <= 1'b0;
    end else begin
      out_val  <= fwd;
      out_sof  <= fwd && (pld_cnt == 16'd0);
      out_eof  <= fwd && last;
      out_err  <= abort;
      pld_done <= (fwd && last) || abort;
      // count restarts whenever the controller leaves the payload
      if (!pld_en) begin
        pld_cnt <= '0;
      end else if (take) begin
        pld_cnt <= pld_cnt + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_dat <= in_dat;
    end
  end

endmodule

/* hw/ipv4_rx_ctrl.sv */
`timescale 1ns/1ps

module ipv4_rx_ctrl (
  input  logic                                clk,
  input  logic                                fsm_rst,
  input  logic                                in_val,
  input  logic                                in_sof,
  input  logic                                in_eof,
  input  logic                                in_err,
  input  logic [15:0]                         in_ethertype,
  input  logic [ipv4_rx_pkg::HDR_IDX_W-1:0]   hdr_bytes,
  input  logic                                fmt_ok,
  input  logic                                addr_ok,
  input  logic                                cks_ok,
  input  logic                                pld_done,
  output logic                                hdr_en,
  output logic [ipv4_rx_pkg::HDR_IDX_W-1:0]   hdr_idx,
  output logic                                cks_clr,
  output logic                                pld_en,
  output logic                                drop_val,
  output ipv4_rx_pkg::drop_reason_t           drop_reason
);
  import ipv4_rx_pkg::*;

  rx_state_t            state;
  rx_state_t            state_nxt;
  logic [HDR_IDX_W-1:0] hdr_cnt;
  logic [HDR_IDX_W-1:0] hdr_last_idx;
  logic                 frame_start;
  logic                 frame_end;
  logic                 is_ipv4;
  logic                 hdr_last;
  logic                 verdict_pass;
  drop_reason_t         verdict_reason;
  logic                 drop_nxt;
  drop_reason_t         reason_nxt;

  // frame flags only count together with a valid byte
  assign frame_start = in_val && in_sof;
  assign frame_end   = in_val && (in_eof || in_err);
  assign is_ipv4     = (in_ethertype == ETHERTYPE_IPV4);

  // an illegal IHL still reads the fixed 20-byte part so the fields are complete
  assign hdr_last_idx = (hdr_bytes < IPV4_MIN_HDR_BYTES) ? IPV4_MIN_HDR_BYTES - 6'd1 :
                                                           hdr_bytes - 6'd1;

  // byte 0 is taken in idle together with in_sof
  assign hdr_idx  = (state == RX_HEADER) ? hdr_cnt : '0;
  assign hdr_en   = in_val && (((state == RX_IDLE) && in_sof && is_ipv4) ||
                               (state == RX_HEADER));
  assign hdr_last = (state == RX_HEADER) && in_val && (hdr_cnt == hdr_last_idx);
  assign cks_clr  = (state == RX_IDLE);

  // failure ranking: format first, then checksum, then address
  always_comb begin
    if (!fmt_ok) begin
      verdict_reason = DROP_BAD_HEADER;
    end else if (!cks_ok) begin
      verdict_reason = DROP_BAD_CHECKSUM;
    end else if (!addr_ok) begin
      verdict_reason = DROP_ADDR_MISMATCH;
    end else begin
      verdict_reason = DROP_NONE;
    end
  end

  assign verdict_pass = (verdict_reason == DROP_NONE);

  // first payload byte may already arrive in the verdict cycle
  assign pld_en = (state == RX_PAYLOAD) || ((state == RX_VERDICT) && verdict_pass);

  always_comb begin
    state_nxt  = state;
    drop_nxt   = 1'b0;
    reason_nxt = DROP_NONE;
    case (state)
      RX_IDLE: begin
        if (frame_start) begin
          if (!is_ipv4) begin
            drop_nxt   = 1'b1;
            reason_nxt = DROP_NOT_IPV4;
            state_nxt  = frame_end ? RX_IDLE : RX_DRAIN;
          end else if (frame_end) begin
            // one-byte frame
            drop_nxt   = 1'b1;
            reason_nxt = DROP_BAD_HEADER;
          end else begin
            state_nxt = RX_HEADER;
          end
        end
      end
      RX_HEADER: begin
        if (frame_end) begin
          // header cut short, nothing left to carry a payload
          drop_nxt   = 1'b1;
          reason_nxt = DROP_BAD_HEADER;
          state_nxt  = RX_IDLE;
        end else if (hdr_last) begin
          state_nxt = RX_VERDICT;
        end
      end
      RX_VERDICT: begin
        drop_nxt   = !verdict_pass;
        reason_nxt = verdict_reason;
        if (frame_end) begin
          state_nxt = RX_IDLE;
        end else if (verdict_pass) begin
          state_nxt = RX_PAYLOAD;
        end else begin
          state_nxt = RX_DRAIN;
        end
      end
      RX_PAYLOAD: begin
        // a trailing eof wins over the done pulse of the last byte
        if (frame_end) begin
          state_nxt = RX_IDLE;
        end else if (pld_done) begin
          state_nxt = RX_DRAIN;
        end
      end
      RX_DRAIN: begin
        if (frame_end) begin
          state_nxt = RX_IDLE;
        end
      end
      default: begin
        state_nxt = RX_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state       <= RX_IDLE;
      hdr_cnt     <= '0;
      drop_val    <= 1'b0;
      drop_reason <= DROP_NONE;
    end else begin
      state    <= state_nxt;
      drop_val <= drop_nxt;
      if (drop_nxt) begin
        drop_reason <= reason_nxt;
      end
      if (hdr_en) begin
        hdr_cnt <= hdr_idx + 6'd1;
      end
    end
  end

endmodule

/* hw/ipv4_rx_pkg.sv */
package ipv4_rx_pkg;

  // ethernet and addressing constants
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [31:0] IPV4_BROADCAST = 32'hffff_ffff;

  localparam int HDR_IDX_W = 6;

  // header size limits in bytes, IHL 5 to 15
  localparam logic [HDR_IDX_W-1:0] IPV4_MIN_HDR_BYTES = 6'd20;
  localparam logic [HDR_IDX_W-1:0] IPV4_MAX_HDR_BYTES = 6'd60;

  localparam logic [3:0] IPV4_VERSION = 4'd4;

  // byte offsets of the captured fields
  localparam logic [HDR_IDX_W-1:0] IPV4_OFS_VER_IHL   = 6'd0;
  localparam logic [HDR_IDX_W-1:0] IPV4_OFS_TOTAL_LEN = 6'd2;
  localparam logic [HDR_IDX_W-1:0] IPV4_OFS_ID        = 6'd4;
  localparam logic [HDR_IDX_W-1:0] IPV4_OFS_PROTO     = 6'd9;
  localparam logic [HDR_IDX_W-1:0] IPV4_OFS_SRC_IP    = 6'd12;
  localparam logic [HDR_IDX_W-1:0] IPV4_OFS_DST_IP    = 6'd16;

  // checksum accumulator keeps the carries of up to 30 header words
  localparam int CKS_ACC_W = 16 + $clog2(IPV4_MAX_HDR_BYTES / 2);

  typedef enum logic [2:0] {
    RX_IDLE    = 3'd0,
    RX_HEADER  = 3'd1,
    RX_VERDICT = 3'd2,
    RX_PAYLOAD = 3'd3,
    RX_DRAIN   = 3'd4
  } rx_state_t;

  typedef enum logic [2:0] {
    DROP_NONE          = 3'd0,
    DROP_NOT_IPV4      = 3'd1,
    DROP_BAD_HEADER    = 3'd2,
    DROP_BAD_CHECKSUM  = 3'd3,
    DROP_ADDR_MISMATCH = 3'd4
  } drop_reason_t;

endpackage

/* hw/ipv4_rx_top.sv */
`timescale 1ns/1ps

module ipv4_rx_top (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  logic [31:0]               dev_ipv4_addr,
  input  logic                      in_val,
  input  logic [7:0]                in_dat,
  input  logic                      in_sof,
  input  logic                      in_eof,
  input  logic                      in_err,
  input  logic [15:0]               in_ethertype,
  output logic                      out_val,
  output logic [7:0]                out_dat,
  output logic                      out_sof,
  output logic                      out_eof,
  output logic                      out_err,
  output logic [31:0]               meta_src_ip,
  output logic [31:0]               meta_dst_ip,
  output logic [7:0]                meta_proto,
  output logic [15:0]               meta_id,
  output logic [15:0]               meta_pld_len,
  output logic                      drop_val,
  output ipv4_rx_pkg::drop_reason_t drop_reason
);
  import ipv4_rx_pkg::*;

  logic                 hdr_en;
  logic [HDR_IDX_W-1:0] hdr_idx;
  logic [HDR_IDX_W-1:0] hdr_bytes;
  logic                 cks_clr;
  logic                 pld_en;
  logic                 fmt_ok;
  logic                 addr_ok;
  logic                 cks_ok;
  logic                 pld_done;

  ipv4_rx_ctrl ctrl_i (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .in_val       (in_val),
    .in_sof       (in_sof),
    .in_eof       (in_eof),
    .in_err       (in_err),
    .in_ethertype (in_ethertype),
    .hdr_bytes    (hdr_bytes),
    .fmt_ok       (fmt_ok),
    .addr_ok      (addr_ok),
    .cks_ok       (cks_ok),
    .pld_done     (pld_done),
    .hdr_en       (hdr_en),
    .hdr_idx      (hdr_idx),
    .cks_clr      (cks_clr),
    .pld_en       (pld_en),
    .drop_val     (drop_val),
    .drop_reason  (drop_reason)
  );

  ipv4_hdr_capture hdr_i (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .hdr_en        (hdr_en),
    .hdr_idx       (hdr_idx),
    .in_dat        (in_dat),
    .dev_ipv4_addr (dev_ipv4_addr),
    .hdr_bytes     (hdr_bytes),
    .fmt_ok        (fmt_ok),
    .addr_ok       (addr_ok),
    .meta_src_ip   (meta_src_ip),
    .meta_dst_ip   (meta_dst_ip),
    .meta_proto    (meta_proto),
    .meta_id       (meta_id),
    .meta_pld_len  (meta_pld_len)
  );

  ipv4_cks_acc cks_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .cks_clr (cks_clr),
    .hdr_en  (hdr_en),
    .hdr_idx (hdr_idx),
    .in_dat  (in_dat),
    .cks_ok  (cks_ok)
  );

  ipv4_pld_fwd pld_i (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .pld_en       (pld_en),
    .in_val       (in_val),
    .in_dat       (in_dat),
    .in_eof       (in_eof),
    .in_err       (in_err),
    .meta_pld_len (meta_pld_len),
    .out_val      (out_val),
    .out_dat      (out_dat),
    .out_sof      (out_sof),
    .out_eof      (out_eof),
    .out_err      (out_err),
    .pld_done     (pld_done)
  );

endmodule

/* list.f */
hw/ipv4_rx_pkg.sv
hw/ipv4_rx_ctrl.sv
hw/ipv4_hdr_capture.sv
hw/ipv4_cks_acc.sv
hw/ipv4_pld_fwd.sv
hw/ipv4_rx_top.sv
verification/ipv4_rx_properties.sv
verification/tb_ipv4_rx.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ipv4 receive testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ipv4_rx -f list.f \
  && ./obj_dir/Vtb_ipv4_rx > sim.log 2>&1
cat sim.log 2>/dev/null
# an assertion stop leaves no pass line, so both messages are searched
grep -q "=== PASS ===" sim.log && ! grep -q "=== FAIL ===" sim.log \
  && echo "simulation passed" && exit 0
echo "simulation failed" || true
exit 1

/* verification/ipv4_rx_properties.sv */
`timescale 1ns/1ps

module ipv4_rx_properties (
  input logic clk,
  input logic fsm_rst,
  input logic out_val,
  input logic out_sof,
  input logic out_eof,
  input logic out_err,
  input logic drop_val
);

  // a frame start always carries its first byte
  a_sof_has_val: assert property (@(posedge clk) disable iff (fsm_rst) out_sof |-> out_val)
    else $error("out_sof without out_val");

  // a payload ends either cleanly or with an error, never both
  a_eof_err_excl: assert property (@(posedge clk) disable iff (fsm_rst) !(out_eof && out_err))
    else $error("out_eof and out_err high together");

  a_drop_no_data: assert property (@(posedge clk) disable iff (fsm_rst) !(drop_val && out_val))
    else $error("drop_val and out_val high together");

  // outputs are quiet right after reset
  a_reset_quiet: assert property (@(posedge clk)
    fsm_rst |=> !(out_val || out_sof || out_eof || out_err || drop_val))
    else $error("output active in the cycle after fsm_rst");

endmodule

bind ipv4_rx_top ipv4_rx_properties props_i (
  .clk      (clk),
  .fsm_rst  (fsm_rst),
  .out_val  (out_val),
  .out_sof  (out_sof),
  .out_eof  (out_eof),
  .out_err  (out_err),
  .drop_val (drop_val)
);

/* verification/tb_ipv4_rx.sv */
`timescale 1ns/1ps

module tb_ipv4_rx;
  import ipv4_rx_pkg::*;

  typedef enum logic [1:0] {EV_EOF, EV_ERR, EV_DROP} ev_kind_t;

  // one entry per frame outcome in the order the frames were sent
  typedef struct packed {
    ev_kind_t     kind;
    drop_reason_t reason;
    logic [15:0]  nbytes;
    logic [31:0]  src;
    logic [31:0]  dst;
    logic [7:0]   proto;
    logic [15:0]  id;
    logic [15:0]  plen;
  } rx_event_t;

  logic         clk;
  logic         fsm_rst;
  logic [31:0]  dev_ipv4_addr;
  logic         in_val;
  logic [7:0]   in_dat;
  logic         in_sof;
  logic         in_eof;
  logic         in_err;
  logic [15:0]  in_ethertype;
  logic         out_val;
  logic [7:0]   out_dat;
  logic         out_sof;
  logic         out_eof;
  logic         out_err;
  logic [31:0]  meta_src_ip;
  logic [31:0]  meta_dst_ip;
  logic [7:0]   meta_proto;
  logic [15:0]  meta_id;
  logic [15:0]  meta_pld_len;
  logic         drop_val;
  drop_reason_t drop_reason;

  logic [7:0]   frm[$];
  logic [7:0]   exp_bytes[$];
  logic [7:0]   got_bytes[$];
  rx_event_t    exp_ev[$];
  rx_event_t    got_ev[$];
  rx_event_t    cur_ev;
  rx_event_t    drop_ev;
  logic [15:0]  cur_cnt;
  logic [31:0]  seed;
  int           ev_rd;
  int           byte_rd;
  int           err_cnt;
  int           timeout_cnt;

  ipv4_rx_top dut_i (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .dev_ipv4_addr (dev_ipv4_addr),
    .in_val        (in_val),
    .in_dat        (in_dat),
    .in_sof        (in_sof),
    .in_eof        (in_eof),
    .in_err        (in_err),
    .in_ethertype  (in_ethertype),
    .out_val       (out_val),
    .out_dat       (out_dat),
    .out_sof       (out_sof),
    .out_eof       (out_eof),
    .out_err       (out_err),
    .meta_src_ip   (meta_src_ip),
    .meta_dst_ip   (meta_dst_ip),
    .meta_proto    (meta_proto),
    .meta_id       (meta_id),
    .meta_pld_len  (meta_pld_len),
    .drop_val      (drop_val),
    .drop_reason   (drop_reason)
  );

  always #2 clk = ~clk;

  // output monitor samples mid-cycle where the registered outputs are stable
  always @(negedge clk) begin
    if (fsm_rst) begin
      cur_ev  = '0;
      cur_cnt = '0;
    end else begin
      // sof only on the first byte, eof on a byte, err without one
      if (out_val && (out_sof != (cur_cnt == 16'd0))) begin
        $display("out_sof is not on the first payload byte of a frame");
        err_cnt++;
      end
      if (out_eof && !out_val) begin
        $display("out_eof came without a payload byte");
        err_cnt++;
      end
      if (out_err && out_val) begin
        $display("out_err came together with a payload byte");
        err_cnt++;
      end
      if (out_sof) begin
        cur_ev.src   = meta_src_ip;
        cur_ev.dst   = meta_dst_ip;
        cur_ev.proto = meta_proto;
        cur_ev.id    = meta_id;
        cur_ev.plen  = meta_pld_len;
      end
      if (out_val) begin
        got_bytes.push_back(out_dat);
        cur_cnt = cur_cnt + 16'd1;
      end
      if (out_eof || out_err) begin
        cur_ev.kind   = out_eof ? EV_EOF : EV_ERR;
        cur_ev.nbytes = cur_cnt;
        got_ev.push_back(cur_ev);
        cur_ev  = '0;
        cur_cnt = '0;
      end
      if (drop_val) begin
        drop_ev        = '0;
        drop_ev.kind   = EV_DROP;
        drop_ev.reason = drop_reason;
        got_ev.push_back(drop_ev);
      end
    end
  end

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_len(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_drop(input string name, input drop_reason_t got, input drop_reason_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic idle_cycles(input int n);
    in_val = 1'b0;
    in_sof = 1'b0;
    in_eof = 1'b0;
    in_err = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // ones-complement sum of the header words with the checksum field still zero
  function automatic logic [15:0] header_checksum(input int hlen);
    logic [31:0] sum;
    int          i;
    sum = '0;
    for (i = 0; i < hlen; i += 2) begin
      sum = sum + {16'd0, frm[i], frm[i+1]};
    end
    while (sum[31:16] != 16'd0) begin
      sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    end
    return ~sum[15:0];
  endfunction

  // builds one frame, records the outcome the header rules call for, then drives it
  task automatic send_ip(input logic [15:0] etype, input int ver, input int ihl,
                         input logic [31:0] dst, input int pld_len, input int min_len,
                         input logic bad_cks, input int cut_pld, input logic err_end,
                         input logic gaps);
    int          hlen;
    int          total;
    int          nsend;
    int          cnt;
    int          i;
    int          g;
    logic [31:0] src;
    logic [31:0] rnd;
    logic [15:0] cks;
    rx_event_t   ev;
    hlen  = 4 * ihl;
    total = hlen + pld_len;
    src   = $urandom;
    rnd   = $urandom;
    frm.delete();
    frm.push_back({ver[3:0], ihl[3:0]});
    frm.push_back(8'h00);
    frm.push_back(total[15:8]);
    frm.push_back(total[7:0]);
    frm.push_back(rnd[15:8]);
    frm.push_back(rnd[7:0]);
    frm.push_back(8'h40);
    frm.push_back(8'h00);
    frm.push_back(8'd64);
    // udp followed by room for the checksum
    frm.push_back(8'd17);
    frm.push_back(8'h00);
    frm.push_back(8'h00);
    for (i = 0; i < 4; i++) begin
      frm.push_back(src[31 - 8*i -: 8]);
    end
    for (i = 0; i < 4; i++) begin
      frm.push_back(dst[31 - 8*i -: 8]);
    end
    // options are NOP bytes
    for (i = 20; i < hlen; i++) begin
      frm.push_back(8'h01);
    end
    cks     = header_checksum(hlen);
    frm[10] = cks[15:8];
    frm[11] = cks[7:0];
    if (bad_cks) begin
      frm[11] = ~frm[11];
    end
    for (i = 0; i < pld_len; i++) begin
      rnd = $urandom;
      frm.push_back(rnd[7:0]);
    end
    while (frm.size() < min_len) begin
      frm.push_back(8'h00);
    end
    nsend = (cut_pld > 0) ? hlen + cut_pld : frm.size();

    ev = '0;
    if (etype != ETHERTYPE_IPV4) begin
      ev.kind   = EV_DROP;
      ev.reason = DROP_NOT_IPV4;
    end else if ((ver != 4) || (ihl < 5) || (pld_len < 1)) begin
      ev.kind   = EV_DROP;
      ev.reason = DROP_BAD_HEADER;
    end else if (bad_cks) begin
      ev.kind   = EV_DROP;
      ev.reason = DROP_BAD_CHECKSUM;
    end else if ((dst != dev_ipv4_addr) && (dst != IPV4_BROADCAST)) begin
      ev.kind   = EV_DROP;
      ev.reason = DROP_ADDR_MISMATCH;
    end else begin
      // an early end aborts on its last byte, so that byte never comes out
      cnt       = (cut_pld > 0) ? cut_pld - 1 : pld_len;
      ev.kind   = (cut_pld > 0) ? EV_ERR : EV_EOF;
      ev.nbytes = cnt[15:0];
      ev.src    = src;
      ev.dst    = dst;
      ev.proto  = 8'd17;
      ev.id     = {frm[4], frm[5]};
      ev.plen   = pld_len[15:0];
      for (i = 0; i < cnt; i++) begin
        exp_bytes.push_back(frm[hlen + i]);
      end
    end
    exp_ev.push_back(ev);

    in_ethertype = etype;
    for (i = 0; i < nsend; i++) begin
      g = 0;
      if (gaps && ($urandom_range(0, 3) == 0)) begin
        g = 1 + int'($urandom_range(0, 2));
      end
      if (g > 0) begin
        idle_cycles(g);
      end
      in_val = 1'b1;
      in_dat = frm[i];
      in_sof = (i == 0);
      in_eof = (i == nsend - 1);
      in_err = err_end && (i == nsend - 1);
      @(negedge clk);
    end
    in_val = 1'b0;
    in_sof = 1'b0;
    in_eof = 1'b0;
    in_err = 1'b0;
  endtask

  // waits for the outcome of every frame sent since the last call, then compares in order
  task automatic check_results(input string tag);
    int        cyc;
    int        i;
    int        n;
    rx_event_t got;
    rx_event_t exp;
    ev_kind_t  got_kind;
    ev_kind_t  exp_kind;
    n   = exp_ev.size();
    cyc = 0;
    while ((got_ev.size() < ev_rd + n) && (cyc < 5000)) begin
      @(negedge clk);
      cyc++;
    end
    if (got_ev.size() < ev_rd + n) begin
      $display("%s: timed out with %0d of %0d frame results", tag, got_ev.size() - ev_rd, n);
      timeout_cnt++;
    end
    // quiet cycles expose results that no frame called for
    idle_cycles(10);
    if (got_ev.size() != ev_rd + n) begin
      $display("%s: DUT reported %0d frame results, %0d expected", tag,
               got_ev.size() - ev_rd, n);
      err_cnt++;
    end
    for (i = 0; (i < n) && (ev_rd + i < got_ev.size()); i++) begin
      got      = got_ev[ev_rd + i];
      exp      = exp_ev[i];
      got_kind = got.kind;
      exp_kind = exp.kind;
      if (got_kind != exp_kind) begin
        $display("%s: frame %0d ended as %s instead of %s", tag, i,
                 got_kind.name(), exp_kind.name());
        err_cnt++;
      end else if (exp_kind == EV_DROP) begin
        check_drop("drop_reason", got.reason, exp.reason);
      end else begin
        check_len("out_val count", got.nbytes, exp.nbytes);
        if (exp_kind == EV_EOF) begin
          check_addr("meta_src_ip", got.src, exp.src);
          check_addr("meta_dst_ip", got.dst, exp.dst);
          check_byte("meta_proto", got.proto, exp.proto);
          check_len("meta_id", got.id, exp.id);
          check_len("meta_pld_len", got.plen, exp.plen);
        end
      end
    end
    if (got_bytes.size() - byte_rd != exp_bytes.size()) begin
      $display("%s: %0d payload bytes forwarded, %0d expected", tag,
               got_bytes.size() - byte_rd, exp_bytes.size());
      err_cnt++;
    end
    for (i = 0; (i < exp_bytes.size()) && (byte_rd + i < got_bytes.size()); i++) begin
      check_byte("out_dat", got_bytes[byte_rd + i], exp_bytes[i]);
    end
    ev_rd   = got_ev.size();
    byte_rd = got_bytes.size();
    exp_ev.delete();
    exp_bytes.delete();
  endtask

  task automatic test_valid_udp();
    send_ip(ETHERTYPE_IPV4, 4, 5, dev_ipv4_addr, 32, 0, 1'b0, 0, 1'b0, 1'b0);
    check_results("valid udp");
  endtask

  task automatic test_addr_filter();
    send_ip(ETHERTYPE_IPV4, 4, 5, IPV4_BROADCAST, 10, 46, 1'b0, 0, 1'b0, 1'b0);
    idle_cycles(2);
    send_ip(ETHERTYPE_IPV4, 4, 5, 32'hc0a8_0a06, 10, 46, 1'b0, 0, 1'b0, 1'b0);
    check_results("address filter");
  endtask

  task automatic test_header_errors();
    send_ip(ETHERTYPE_IPV4, 4, 5, dev_ipv4_addr, 16, 46, 1'b1, 0, 1'b0, 1'b0);
    idle_cycles(2);
    send_ip(16'h0806, 4, 5, dev_ipv4_addr, 16, 46, 1'b0, 0, 1'b0, 1'b0);
    idle_cycles(2);
    send_ip(ETHERTYPE_IPV4, 6, 5, dev_ipv4_addr, 16, 46, 1'b0, 0, 1'b0, 1'b0);
    check_results("header errors");
  endtask

  task automatic test_options_padding();
    send_ip(ETHERTYPE_IPV4, 4, 6, dev_ipv4_addr, 6, 46, 1'b0, 0, 1'b0, 1'b0);
    check_results("options and padding");
  endtask

  task automatic test_early_end();
    send_ip(ETHERTYPE_IPV4, 4, 5, dev_ipv4_addr, 40, 0, 1'b0, 25, 1'b0, 1'b0);
    idle_cycles(2);
    send_ip(ETHERTYPE_IPV4, 4, 5, dev_ipv4_addr, 40, 0, 1'b0, 12, 1'b1, 1'b0);
    check_results("early end");
  endtask

  // back-to-back frames with random gaps inside each frame
  task automatic test_random_stream();
    int k;
    int mode;
    int plen;
    for (k = 0; k < 12; k++) begin
      mode = int'($urandom_range(0, 4));
      plen = int'($urandom_range(1, 40));
      case (mode)
        0: send_ip(ETHERTYPE_IPV4, 4, 5, dev_ipv4_addr, plen, 0, 1'b0, 0, 1'b0, 1'b1);
        1: send_ip(ETHERTYPE_IPV4, 4, 5, IPV4_BROADCAST, plen, 46, 1'b0, 0, 1'b0, 1'b1);
        2: send_ip(ETHERTYPE_IPV4, 4, 5, 32'h0a0b_0c0d, plen, 46, 1'b0, 0, 1'b0, 1'b1);
        3: send_ip(ETHERTYPE_IPV4, 4, 5, dev_ipv4_addr, plen, 46, 1'b1, 0, 1'b0, 1'b1);
        default: send_ip(16'h86dd, 4, 5, dev_ipv4_addr, plen, 46, 1'b0, 0, 1'b0, 1'b1);
      endcase
    end
    check_results("random stream");
  endtask

  initial begin
    seed          = $urandom(32'h99a9_f20a);
    clk           = 1'b0;
    fsm_rst       = 1'b1;
    dev_ipv4_addr = 32'hc0a8_0a05;
    in_val        = 1'b0;
    in_dat        = 8'h00;
    in_sof        = 1'b0;
    in_eof        = 1'b0;
    in_err        = 1'b0;
    in_ethertype  = 16'h0000;
    ev_rd         = 0;
    byte_rd       = 0;
    err_cnt       = 0;
    timeout_cnt   = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0;
    idle_cycles(2);

    test_valid_udp();
    test_addr_filter();
    test_header_errors();
    test_options_padding();
    test_early_end();
    test_random_stream();

    $display("checks done: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
    if ((err_cnt == 0) && (timeout_cnt == 0)) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
